// ==== hw/snes_mem_pkg.sv ====
`default_nettype none

package snes_mem_pkg;

    localparam int ADDR_W      = 24;          // byte address into memory
    localparam int DATA_W      = 16;          // memory word
    localparam int WRAM_ADDR_W = 17;          // 128 KB work RAM

    // banks EE/EF hold work RAM
    localparam logic [6:0] WRAM_BASE_HI = 7'b1110_111;

    // ROM side as seen from the core
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              ce_n;
        logic              word;              // 16-bit fetch, no swap
    } rom_bus_t;

    // work RAM side, byte wide
    typedef struct packed {
        logic [WRAM_ADDR_W-1:0] addr;
        logic                   ce_n;
        logic                   rd_n;
        logic                   we_n;
        logic [7:0]             d;            // write byte
    } wram_bus_t;

    // one byte per valid from the loader
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } loader_t;

    // single registered request into the memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] din;
        logic [1:0]        ds;                // byte enables, [1] = high lane
        logic              port;              // 0 rom, 1 work ram
        logic              rd;
        logic              wr;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/cycle_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_gate #(
    parameter int RESET_HOLD = 16
) (
    input  logic wclk,
    input  logic resetn,
    input  logic pause,        // frame sync hold
    input  logic sysclkf_ce,   // raw fall strobe
    input  logic sysclkr_ce,   // raw rise strobe
    output logic enable,
    output logic f2,
    output logic r2
);

    // wide enough to hold RESET_HOLD itself
    localparam int CNT_W = (RESET_HOLD < 1) ? 1 : $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;   // cycles left before start
    logic             hold_done;

    assign hold_done = (hold_cnt == '0);

    // reset release, then pause decides
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            hold_cnt <= CNT_W'(RESET_HOLD);
            enable   <= 1'b0;
        end else begin
            if (!hold_done) begin
                hold_cnt <= hold_cnt - 1'b1;
                enable   <= 1'b0;      // still holding
            end else begin
                enable   <= ~pause;    // drops one edge after pause
            end
        end
    end

    // strobes only count while the core runs
    // uses current enable, so first strobe after start lands a cycle late
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            f2 <= 1'b0;
            r2 <= 1'b0;
        end else begin
            f2 <= sysclkf_ce & enable;
            r2 <= sysclkr_ce & enable;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_request
    import snes_mem_pkg::*;
(
    input  logic      wclk,
    input  logic      resetn,
    input  logic      f2,          // gated fall strobe
    input  logic      r2,          // gated rise strobe
    input  logic      loading,
    input  loader_t   loader,
    input  rom_bus_t  rom,
    input  wram_bus_t wram,
    output mem_req_t  req
);

    logic [ADDR_W-1:0] loader_addr;   // next byte position
    logic              loading_r;     // for the rising edge of loading
    logic              load_wr;
    logic              rom_rd;
    logic              wram_rd;
    logic              wram_wr;
    logic              wram_rd_go;
    logic              wram_wr_go;
    logic [ADDR_W-1:0] wram_full;     // work ram placed in its banks

    assign load_wr    = loading & loader.valid;
    assign rom_rd     = ~rom.ce_n & f2;
    assign wram_rd    = ~wram.ce_n & ~wram.rd_n;
    assign wram_wr    = ~wram.ce_n & ~wram.we_n;
    assign wram_rd_go = wram_rd & f2;              // reads on fall cycles
    assign wram_wr_go = wram_wr & r2;              // writes on rise cycles
    assign wram_full  = {WRAM_BASE_HI, wram.addr};

    // loader address restarts at every new load
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loader_addr <= '0;
            loading_r   <= 1'b0;
        end else begin
            loading_r <= loading;
            if (loader.valid)
                loader_addr <= loader_addr + 1'b1;
            if (loading & ~loading_r)
                loader_addr <= '0;                 // wins over increment
        end
    end

    // one request per cycle with the loader first
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            req <= '0;
        end else begin
            req <= '0;                              // idle unless chosen below
            if (load_wr) begin
                req.addr <= loader_addr;
                req.din  <= {loader.data, loader.data};   // same byte on both lanes
                req.ds   <= {loader_addr[0], ~loader_addr[0]};
                req.wr   <= 1'b1;
            end else if (rom_rd) begin
                req.addr <= rom.addr;
                req.ds   <= 2'b11;                  // full word, lane picked on return
                req.rd   <= 1'b1;
            end else if (wram_rd_go) begin
                req.addr <= wram_full;
                req.ds   <= {wram.addr[0], ~wram.addr[0]};
                req.din  <= {wram.d, wram.d};
                req.port <= 1'b1;
                req.rd   <= 1'b1;
            end else if (wram_wr_go) begin
                req.addr <= wram_full;
                req.ds   <= {wram.addr[0], ~wram.addr[0]};
                req.din  <= {wram.d, wram.d};
                req.port <= 1'b1;
                req.wr   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_model
    import snes_mem_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 12
) (
    input  logic              wclk,
    input  logic              resetn,
    input  mem_req_t          req,
    output logic [DATA_W-1:0] port0,   // rom read data, held
    output logic [DATA_W-1:0] port1    // work ram read data, held
);

    // bit 23 picks the upper of two halves
    localparam int IDX_W = MEM_ADDR_BITS + 1;
    localparam int DEPTH = 1 << IDX_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] rd_word;

    // byte address -> word index
    assign idx     = {req.addr[ADDR_W-1], req.addr[MEM_ADDR_BITS:1]};
    assign rd_word = mem[idx];

    // lane masked writes
    always_ff @(posedge wclk) begin
        if (req.wr) begin
            if (req.ds[0])
                mem[idx][7:0] <= req.din[7:0];
            if (req.ds[1])
                mem[idx][15:8] <= req.din[15:8];
        end
    end

    // each port keeps its last read until the next one
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            port0 <= '0;
            port1 <= '0;
        end else if (req.rd) begin
            if (req.port)
                port1 <= rd_word;   // work ram
            else
                port0 <= rd_word;   // rom
        end
    end

endmodule

`default_nettype wire

// ==== hw/read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return
    import snes_mem_pkg::*;
(
    input  logic              wclk,
    input  logic              resetn,
    input  mem_req_t          req,
    input  logic              rom_word,   // word fetch flag from the core
    input  logic [DATA_W-1:0] port0,
    input  logic [DATA_W-1:0] port1,
    output logic [DATA_W-1:0] rom_q,
    output logic [7:0]        wram_q
);

    logic rom_lsb;       // byte lane of last rom read
    logic rom_word_r;
    logic wram_lsb;      // byte lane of last work ram read

    // latched on the same edge the model loads its port
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rom_lsb    <= 1'b0;
            rom_word_r <= 1'b0;
            wram_lsb   <= 1'b0;
        end else if (req.rd) begin
            if (req.port) begin
                wram_lsb <= req.addr[0];
            end else begin
                rom_lsb    <= req.addr[0];
                rom_word_r <= rom_word;
            end
        end
    end

    // odd byte reads see the swapped word, so the byte sits low
    assign rom_q  = (rom_word_r || !rom_lsb) ? port0 : {port0[7:0], port0[15:8]};
    assign wram_q = wram_lsb ? port1[15:8] : port1[7:0];

endmodule

`default_nettype wire

// ==== hw/snes_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_mem_top
    import snes_mem_pkg::*;
#(
    parameter int RESET_HOLD    = 16,   // cycles before enable
    parameter int MEM_ADDR_BITS = 12    // words per memory half, log2
) (
    input  logic              wclk,
    input  logic              resetn,
    input  logic              pause,
    input  logic              sysclkf_ce,
    input  logic              sysclkr_ce,
    input  logic              loading,
    input  loader_t           loader,
    input  rom_bus_t          rom,
    input  wram_bus_t         wram,
    output logic              enable,
    output logic [DATA_W-1:0] rom_q,
    output logic [7:0]        wram_q
);

    logic              f2;       // gated fall strobe
    logic              r2;       // gated rise strobe
    mem_req_t          req;
    logic [DATA_W-1:0] port0;
    logic [DATA_W-1:0] port1;

    // run enable and strobes
    cycle_gate #(
        .RESET_HOLD (RESET_HOLD)
    ) u_cycle_gate (
        .wclk       (wclk),
        .resetn     (resetn),
        .pause      (pause),
        .sysclkf_ce (sysclkf_ce),
        .sysclkr_ce (sysclkr_ce),
        .enable     (enable),
        .f2         (f2),
        .r2         (r2)
    );

    // loader counter and arbiter
    mem_request u_mem_request (
        .wclk    (wclk),
        .resetn  (resetn),
        .f2      (f2),
        .r2      (r2),
        .loading (loading),
        .loader  (loader),
        .rom     (rom),
        .wram    (wram),
        .req     (req)
    );

    // stands in for the sdram controller and is never busy
    sdram_model #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_sdram_model (
        .wclk   (wclk),
        .resetn (resetn),
        .req    (req),
        .port0  (port0),
        .port1  (port1)
    );

    // word flag goes straight from the core to the return stage
    read_return u_read_return (
        .wclk     (wclk),
        .resetn   (resetn),
        .req      (req),
        .rom_word (rom.word),
        .port0    (port0),
        .port1    (port1),
        .rom_q    (rom_q),
        .wram_q   (wram_q)
    );

endmodule

`default_nettype wire

// ==== sim/snes_mem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_mem_assert
    import snes_mem_pkg::*;
(
    input logic     wclk,
    input logic     resetn,
    input logic     loading,
    input logic     f2,
    input logic     r2,
    input mem_req_t req
);

    // one direction per request
    a_rd_wr_excl: assert property (@(posedge wclk) disable iff (!resetn)
        !(req.rd && req.wr))
        else $error("request has rd and wr set together");

    // port 1 only inside banks EE/EF
    a_port_bank: assert property (@(posedge wclk) disable iff (!resetn)
        req.port |-> (req.addr[ADDR_W-1 -: 7] == WRAM_BASE_HI))
        else $error("work ram port with address %h outside its banks", req.addr);

    // every request needs a loader byte or a strobe one cycle back
    a_req_cause: assert property (@(posedge wclk) disable iff (!resetn)
        (req.rd || req.wr) |-> ($past(loading) || $past(f2) || $past(r2)))
        else $error("request issued without loading or a strobe");

endmodule

bind mem_request snes_mem_assert u_assert (
    .wclk    (wclk),
    .resetn  (resetn),
    .loading (loading),
    .f2      (f2),
    .r2      (r2),
    .req     (req)
);

`default_nettype wire

// ==== sim/tb_snes_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_snes_mem
    import snes_mem_pkg::*;
();

    localparam int RESET_HOLD = 16;
    localparam int CLK_P      = 20;      // ns

    typedef enum logic [2:0] {OP_PAUSE, OP_LOAD, OP_ROM, OP_HOLD, OP_WR, OP_RD} op_t;

    typedef struct packed {
        op_t         op;
        logic [23:0] addr;       // byte address, byte count for a load
        logic [7:0]  data;       // work ram write byte
        logic        word;       // rom word flag
        logic [15:0] exp_val;
        logic        from_ref;   // expected value from the reference bytes
    } row_t;

    logic              wclk = 1'b0;
    logic              resetn;
    logic              pause;
    logic              sysclkf_ce;
    logic              sysclkr_ce;
    logic              loading;
    loader_t           loader;
    rom_bus_t          rom;
    wram_bus_t         wram;
    logic              enable;
    logic [DATA_W-1:0] rom_q;
    logic [7:0]        wram_q;

    row_t       rows [64];
    int         n_rows = 0;
    int         n_tests = 0;
    int         n_errors = 0;
    logic       table_ready = 1'b0;
    logic [7:0] rom_ref [64];    // loaded bytes by address
    integer     seed;
    integer     rnd;

    snes_mem_top #(.RESET_HOLD(RESET_HOLD), .MEM_ADDR_BITS(12)) uut (.*);

    always #(CLK_P / 2) wclk = ~wclk;

    task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, want);
            n_errors++;
        end
    endtask

    task automatic add_row(input op_t op, input logic [23:0] addr, input logic [7:0] data,
                           input logic word, input logic [15:0] exp_val, input logic from_ref);
        rows[n_rows[5:0]] = {op, addr, data, word, exp_val, from_ref};
        n_rows++;
    endtask

    // even byte low, odd byte high; swapped for a byte fetch at an odd address
    function automatic logic [15:0] rom_expect(input logic [23:0] addr, input logic word);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = rom_ref[{addr[5:1], 1'b0}];
        hi = rom_ref[{addr[5:1], 1'b1}];
        return (word || !addr[0]) ? {hi, lo} : {lo, hi};
    endfunction

    task automatic load_bytes(input int count);
        @(negedge wclk);
        loading      = 1'b1;            // rising edge clears the address
        loader.valid = 1'b0;
        for (int i = 0; i < count; i++) begin
            @(negedge wclk);
            rnd             = $random(seed);
            loader.data     = rnd[7:0];
            loader.valid    = 1'b1;
            rom_ref[i[5:0]] = rnd[7:0];
        end
        @(negedge wclk);
        loader.valid = 1'b0;
        loading      = 1'b0;
        @(negedge wclk);                // last write lands
    endtask

    // one rom or work ram access sampled after the 3rd edge
    task automatic access(input row_t r, output logic [15:0] got);
        logic is_rom;
        logic is_wr;
        logic strobe;
        is_rom = (r.op == OP_ROM) || (r.op == OP_HOLD);
        is_wr  = (r.op == OP_WR);
        strobe = (r.op != OP_HOLD);
        @(negedge wclk);
        rom.addr   = r.addr;
        rom.word   = r.word;
        rom.ce_n   = ~is_rom;
        wram.addr  = r.addr[16:0];
        wram.d     = r.data;
        wram.ce_n  = is_rom;
        wram.rd_n  = is_wr;
        wram.we_n  = ~is_wr;
        sysclkf_ce = strobe & ~is_wr;   // reads on fall cycles
        sysclkr_ce = strobe & is_wr;    // writes on rise cycles
        @(negedge wclk);
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        repeat (2) @(negedge wclk);     // request edge, then data edge
        got       = is_rom ? rom_q : {8'h00, wram_q};
        rom.ce_n  = 1'b1;
        wram.ce_n = 1'b1;
    endtask

    task automatic report(input string desc, input int errs_before);
        n_tests++;
        if (n_errors == errs_before)
            $display("%s: ok", desc);
        else
            $display("%s: mismatch", desc);
    endtask

    task automatic build_table();
        add_row(OP_PAUSE, 24'd0, 8'h00, 1'b0, 16'h0001, 1'b0);   // enable back after pause
        add_row(OP_LOAD, 24'd32, 8'h00, 1'b0, 16'h0000, 1'b0);
        for (int a = 0; a < 32; a += 2)
            add_row(OP_ROM, 24'(a), 8'h00, 1'b1, 16'h0000, 1'b1);
        add_row(OP_ROM, 24'd1, 8'h00, 1'b0, 16'h0000, 1'b1);     // odd byte fetches
        add_row(OP_ROM, 24'd7, 8'h00, 1'b0, 16'h0000, 1'b1);
        add_row(OP_ROM, 24'd19, 8'h00, 1'b0, 16'h0000, 1'b1);
        add_row(OP_ROM, 24'd12, 8'h00, 1'b0, 16'h0000, 1'b1);    // even byte, no swap
        add_row(OP_WR, 24'd5, 8'ha5, 1'b0, 16'h0000, 1'b0);
        add_row(OP_WR, 24'd4, 8'h3c, 1'b0, 16'h0000, 1'b0);
        add_row(OP_RD, 24'd5, 8'h00, 1'b0, 16'h00a5, 1'b0);
        add_row(OP_RD, 24'd4, 8'h00, 1'b0, 16'h003c, 1'b0);
        add_row(OP_ROM, 24'd4, 8'h00, 1'b1, 16'h0000, 1'b1);     // same low bits as wram
        add_row(OP_ROM, 24'd5, 8'h00, 1'b0, 16'h0000, 1'b1);
        add_row(OP_HOLD, 24'd10, 8'h00, 1'b1, 16'h0000, 1'b0);
        add_row(OP_LOAD, 24'd8, 8'h00, 1'b0, 16'h0000, 1'b0);    // restarts at 0
        for (int a = 0; a <= 8; a += 2)
            add_row(OP_ROM, 24'(a), 8'h00, 1'b1, 16'h0000, 1'b1);
    endtask

    initial begin
        row_t        r;
        logic [15:0] want;
        logic [15:0] got;
        logic [15:0] rom_last;
        int          errs_before;

        seed       = 32'h57c69996;
        resetn     = 1'b0;
        pause      = 1'b0;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        loading    = 1'b0;
        loader     = '0;
        rom        = '{addr: '0, ce_n: 1'b1, word: 1'b0};
        wram       = '{addr: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1, d: '0};
        rom_last   = '0;
        build_table();
        table_ready = 1'b1;

        // enable stays low through 4 reset cycles and the hold
        errs_before = n_errors;
        for (int c = 0; c <= 4 + RESET_HOLD; c++) begin
            @(negedge wclk);
            check_val("enable at startup", {15'd0, enable}, {15'd0, c == 4 + RESET_HOLD});
            if (c == 3)
                resetn = 1'b1;
        end
        report("startup enable", errs_before);

        for (int i = 0; i < n_rows; i++) begin
            r           = rows[i[5:0]];
            errs_before = n_errors;
            want        = r.from_ref ? rom_expect(r.addr, r.word) : r.exp_val;
            case (r.op)
                OP_PAUSE: begin
                    @(negedge wclk);
                    pause = 1'b1;
                    @(negedge wclk);
                    check_val("enable under pause", {15'd0, enable}, 16'd0);
                    pause = 1'b0;
                    @(negedge wclk);
                    check_val("enable after pause", {15'd0, enable}, want);
                end
                OP_LOAD: load_bytes(int'(r.addr));
                default: begin
                    if (r.op == OP_HOLD)
                        want = rom_last;        // no strobe keeps the last rom result
                    access(r, got);
                    if (r.op != OP_WR)
                        check_val($sformatf("%s at %h", r.op.name(), r.addr), got, want);
                    if (r.op == OP_ROM)
                        rom_last = want;
                end
            endcase
            report($sformatf("row %0d %s addr %h", i, r.op.name(), r.addr), errs_before);
        end

        $display("tests run: %0d, errors: %0d", n_tests, n_errors);
        if (n_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // run limit from the table length
    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = n_rows * 40 + 4 + RESET_HOLD;
        #(limit * CLK_P);
        $display("watchdog expired, the table did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/snes_mem_pkg.sv
hw/cycle_gate.sv
hw/mem_request.sv
hw/sdram_model.sv
hw/read_return.sv
hw/snes_mem_top.sv
sim/snes_mem_assert.sv
sim/tb_snes_mem.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_snes_mem -f sources.f \
    && ./obj_dir/Vtb_snes_mem | tee /dev/stderr | grep -qx "test passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
